// ==== spiBlock.f ====
+incdir+.
spiPkg.sv
spiCsr.sv
spiShiftEngine.sv
spiRxCapture.sv
spiBlock.sv
tbClockGen.sv
spiSlaveModel.sv
spiBlock_tb.sv

// ==== Makefile ====
# Verilator flow for the SPI master block

VERILATOR ?= verilator
TOP       ?= spiBlock_tb
RTL_TOP   ?= spiBlock
FILELIST  ?= spiBlock.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -F -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== spiBlock_tb.sv ====
/*
 * Testbench top of the SPI master block
 * Stimulus table, bus tasks, compare tasks, timeouts, summary line
 */
`timescale 1ns/10ps
`default_nettype none
`include "spiBlock_config.svh"

module spiBlock_tb
	import spiPkg::*;
();

	typedef struct packed {
		logic [15:0] div;
		logic [7:0]  txByte;
		logic        cs1Sel;
		logic        cs2Sel;
		logic        irqEn;
	} stimRow_t;

	localparam int NUM_ROWS = 5;
	localparam logic [7:0] OTHER_BLK = 8'h04;		// Some other block on the bus
	localparam spiPins_t PINS_IDLE = '{sck: 1'b0, mosi: 1'b0, cs1N: 1'b1, cs2N: 1'b1};

	logic        sysClk;
	logic        rstN;
	busWr_t      busWr;
	logic        rdCke;
	wire         miso;
	busRd_t      busRd;
	spiPins_t    pins;
	logic        irq;
	logic [7:0]  slaveRx;
	stimRow_t    stimTable [NUM_ROWS];
	int          errCount;
	int          toCount;
	logic [7:0]  expReply;		// Slave answer for the next transfer
	logic [31:0] lcgState;

	tbClockGen clkGen_i (.sysClk(sysClk), .rstN(rstN));

	spiBlock dut_i (
		.sysClk(sysClk), .rstN(rstN), .busWr(busWr), .rdCke(rdCke), .miso(miso),
		.busRd(busRd), .pins(pins), .irq(irq)
	);

	spiSlaveModel slave_i (.pins(pins), .miso(miso), .lastRx(slaveRx));

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [`SPI_BUS_ADRS_BIT-1:0] regAdrs(input csrReg_e ofs,
		input logic [7:0] blk);
		return {blk, 5'd0, ofs};
	endfunction

	//--------------------------------------------------
	// Compare tasks
	//--------------------------------------------------
	task automatic checkRd(input busRd_t got, input logic [31:0] exp, input string what);
		if (!got.vd || got.rd !== exp)
		begin
			errCount++;
			$display("FAILED at %0t ns: read %s gave %h vd %b, expected %h", $time, what,
				got.rd, got.vd, exp);
		end
	endtask

	task automatic checkPins(input spiPins_t got, input spiPins_t exp, input string what);
		if (got !== exp)
		begin
			errCount++;
			$display("FAILED at %0t ns: %s pins %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
		begin
			errCount++;
			$display("FAILED at %0t ns: %s %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		if (got != exp)
		begin
			errCount++;
			$display("FAILED at %0t ns: %s %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	//--------------------------------------------------
	// Bus access, driven 2 ns after the edge
	//--------------------------------------------------
	task automatic busWrite(input logic [`SPI_BUS_ADRS_BIT-1:0] adrs, input logic [31:0] data);
		busWr = '{adrs: adrs, wd: data, wCke: 1'b1};
		@(posedge sysClk);
		#2 busWr.wCke = 1'b0;
	endtask

	task automatic busRead(input logic [`SPI_BUS_ADRS_BIT-1:0] adrs, input logic expectVd,
		output busRd_t got);
		int n;
		busWr.adrs = adrs;
		rdCke = 1'b1;
		@(posedge sysClk);
		#2 rdCke = 1'b0;
		n = 0;
		while (!busRd.vd && n < 4)		// vd due right after the strobe edge
		begin
			@(posedge sysClk);
			#2 n++;
		end
		got = busRd;
		if (expectVd && !got.vd)
		begin
			toCount++;
			$display("Timeout at %0t ns: no read valid within 4 cycles at %h", $time, adrs);
		end
	endtask

	//--------------------------------------------------
	// One transfer with timing, select and irq checks
	//--------------------------------------------------
	task automatic runTransfer(input stimRow_t row, input logic [7:0] tx);
		busRd_t   r;
		spiPins_t expPins;
		int       n;
		int       busyCycles;
		int       sinceEdge;
		int       sckEdges;
		int       irqPulses;
		int       halfIdx;
		int       bitIdx;
		logic     prevSck;
		busWrite(regAdrs(REG_CTRL, `SPI_ADRS_MAP),
			{28'd0, row.irqEn, row.cs2Sel, row.cs1Sel, 1'b1});
		busWrite(regAdrs(REG_DIV, `SPI_ADRS_MAP), {16'd0, row.div});
		busWrite(regAdrs(REG_TX, `SPI_ADRS_MAP), {24'd0, tx});
		n = 0;
		while (!dut_i.busy && n < 8)
		begin
			@(posedge sysClk);
			#2 n++;
		end
		if (!dut_i.busy)
		begin
			toCount++;
			$display("Timeout at %0t ns: busy did not rise after the TX write", $time);
		end
		busyCycles = 0;
		sinceEdge  = 0;
		sckEdges   = 0;
		irqPulses  = 0;
		prevSck    = 1'b0;
		while (dut_i.busy && busyCycles < 18 * (row.div + 1) + 8)
		begin
			busyCycles++;
			sinceEdge++;
			halfIdx = (busyCycles - 1) / (row.div + 1);	// 0 LEAD, 1..16 SCK, 17 TRAIL
			bitIdx  = (halfIdx < 3) ? 0 : (halfIdx - 1) / 2;	// MOSI moves on each fall
			if (bitIdx > 7)
				bitIdx = 7;
			expPins = '{sck: (halfIdx >= 2 && halfIdx <= 16 && halfIdx % 2 == 0),
				mosi: tx[7 - bitIdx], cs1N: !row.cs1Sel, cs2N: !row.cs2Sel};
			checkPins(pins, expPins, "pins during transfer");
			if (pins.sck !== prevSck)
			begin
				if (sckEdges > 0)	// Half period between any two SCK edges
					checkCount(sinceEdge, row.div + 1, "clocks between SCK edges");
				sckEdges++;
				sinceEdge = 0;
				prevSck   = pins.sck;
			end
			irqPulses += irq;
			@(posedge sysClk);
			#2;
		end
		if (dut_i.busy)
		begin
			toCount++;
			$display("Timeout at %0t ns: busy did not fall at the end of the transfer", $time);
		end
		checkCount(busyCycles, 18 * (row.div + 1), "busy length in clocks");
		checkCount(sckEdges, 16, "SCK edges");
		for (n = 0; n < 4; n++)		// irq lands one clock after done
		begin
			irqPulses += irq;
			@(posedge sysClk);
			#2;
		end
		if (row.irqEn && irqPulses == 0)
		begin
			toCount++;
			$display("Timeout at %0t ns: no interrupt after the transfer", $time);
		end
		else
			checkCount(irqPulses, row.irqEn, "irq pulses");
		checkPins(pins, PINS_IDLE, "pins after transfer");
		checkByte(slaveRx, tx, "byte seen by slave");
		busRead(regAdrs(REG_RX, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, {24'd0, expReply}, "RX");
		busRead(regAdrs(REG_STATUS, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'h2, "STATUS after transfer");	// done 1, busy 0
		expReply = tx ^ 8'hA5;
	endtask

	//--------------------------------------------------
	// Main sequence
	//--------------------------------------------------
	initial
	begin
		busRd_t r;
		int     n;
		busWr    = '0;
		rdCke    = 1'b0;
		errCount = 0;
		toCount  = 0;
		expReply = 8'hA5;		// Slave answer on the very first transfer
		lcgState = 32'h1addeedd;
		// div, txByte, cs1Sel, cs2Sel, irqEn
		stimTable[0] = '{16'd0, 8'h3C, 1'b1, 1'b0, 1'b1};
		stimTable[1] = '{16'd1, 8'hC5, 1'b0, 1'b1, 1'b0};
		stimTable[2] = '{16'd3, 8'h81, 1'b1, 1'b1, 1'b1};
		stimTable[3] = '{16'd2, 8'h00, 1'b1, 1'b0, 1'b0};
		stimTable[4] = '{16'd0, 8'hFF, 1'b0, 1'b1, 1'b1};
		n = 0;
		while (!rstN && n < 20)
		begin
			@(posedge sysClk);
			n++;
		end
		if (!rstN)
		begin
			toCount++;
			$display("Timeout at %0t ns: reset was never released", $time);
		end
		#2;
		// Reset state
		checkPins(pins, PINS_IDLE, "pins after reset");
		busRead(regAdrs(REG_CTRL, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'd0, "CTRL after reset");
		busRead(regAdrs(REG_DIV, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'd0, "DIV after reset");
		busRead(regAdrs(REG_RX, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'd0, "RX after reset");
		busRead(regAdrs(REG_STATUS, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'd0, "STATUS after reset");
		// Register access, other block must not touch ours
		busWrite(regAdrs(REG_CTRL, `SPI_ADRS_MAP), 32'hB);
		busWrite(regAdrs(REG_DIV, `SPI_ADRS_MAP), 32'h1234);
		busWrite(regAdrs(REG_CTRL, OTHER_BLK), 32'h5);
		busWrite(regAdrs(REG_DIV, OTHER_BLK), 32'h77);
		busRead(regAdrs(REG_CTRL, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'hB, "CTRL readback");
		busRead(regAdrs(REG_DIV, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'h1234, "DIV readback");
		busRead(regAdrs(REG_CTRL, OTHER_BLK), 1'b0, r);
		if (r.vd)
		begin
			errCount++;
			$display("FAILED at %0t ns: read of another block gave vd", $time);
		end
		// Enable clear, TX write dropped
		busWrite(regAdrs(REG_CTRL, `SPI_ADRS_MAP), 32'h6);
		busWrite(regAdrs(REG_TX, `SPI_ADRS_MAP), 32'h5A);
		for (n = 0; n < 10; n++)
		begin
			checkPins(pins, PINS_IDLE, "pins with enable clear");
			@(posedge sysClk);
			#2;
		end
		busRead(regAdrs(REG_STATUS, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'd0, "STATUS with enable clear");
		busRead(regAdrs(REG_TX, `SPI_ADRS_MAP), 1'b1, r);
		checkRd(r, 32'd0, "TX reads as zero");
		// Table rows, each followed by an LCG byte
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			runTransfer(stimTable[i], stimTable[i].txByte);
			lcgState = lcgNext(lcgState);
			runTransfer(stimTable[i], lcgState[23:16]);
		end
		$display("Summary: %0d value errors, %0d timeouts", errCount, toCount);
		if (errCount == 0 && toCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== spiSlaveModel.sv ====
/*
 * Testbench SPI slave, mode 0, MSB first
 * Records the MOSI byte, answers with the previous byte XOR 8'hA5
 */
`timescale 1ns/10ps
`default_nettype none

module spiSlaveModel
	import spiPkg::*;
(
	input  wire spiPins_t pins,
	output wire           miso,
	output logic [7:0]    lastRx	// Last complete MOSI byte
);

	wire        csN;
	logic       csPrev  = 1'b1;
	logic       sckPrev = 1'b0;
	logic [7:0] txShift = 8'd0;
	logic [7:0] rxShift = 8'd0;
	logic [7:0] reply   = 8'hA5;	// Answer for the next transfer

	assign csN  = pins.cs1N & pins.cs2N;	// Either select
	assign miso = txShift[7];

	// Edge tracking in one block
	always @(csN or pins.sck)
	begin
		if (csN !== csPrev && csN === 1'b0)
			txShift = reply;		// Selected, first bit out at once
		else if (csN !== csPrev && csN === 1'b1)
		begin
			lastRx = rxShift;
			reply  = rxShift ^ 8'hA5;
		end
		else if (!csN && pins.sck === 1'b1 && sckPrev === 1'b0)
			rxShift = {rxShift[6:0], pins.mosi};	// MOSI in on the rise
		else if (!csN && pins.sck === 1'b0 && sckPrev === 1'b1)
			txShift = {txShift[6:0], 1'b0};	// MISO out on the fall
		csPrev  = csN;
		sckPrev = pins.sck;
	end

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
/*
 * Testbench clock and reset
 * 20 ns clock, synchronous active-low reset held for 10 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tbClockGen (
	output logic sysClk,
	output logic rstN
);

	localparam int HALF_PERIOD = 10;	// 20 ns period
	localparam int RST_CYCLES  = 10;

	initial
	begin
		sysClk = 1'b0;
		forever #HALF_PERIOD sysClk = ~sysClk;
	end

	// Released 2 ns after an edge, like all stimulus
	initial
	begin
		rstN = 1'b0;
		repeat (RST_CYCLES) @(posedge sysClk);
		#2 rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== spiBlock.sv ====
/*
 * SPI master block top level
 * Register file, shift engine and receive capture
 */
`timescale 1ns/10ps
`default_nettype none

module spiBlock
	import spiPkg::*;
(
	input  wire         sysClk,
	input  wire         rstN,
	input  wire busWr_t busWr,
	input  wire         rdCke,
	input  wire         miso,
	output busRd_t      busRd,
	output spiPins_t    pins,
	output logic        irq
);

	spiCtrl_t   ctrl;
	logic       start;
	logic [7:0] txByte;
	logic       busy;
	logic       done;
	logic [7:0] rxByte;		// Engine shift register
	logic [7:0] rxData;		// Held copy for reads
	logic       doneFlag;

	//--------------------------------------------------
	// Register file
	//--------------------------------------------------
	spiCsr csr_i (
		.sysClk(sysClk), .rstN(rstN), .busWr(busWr), .rdCke(rdCke), .busy(busy),
		.rxData(rxData), .doneFlag(doneFlag), .busRd(busRd), .ctrl(ctrl),
		.start(start), .txByte(txByte)
	);

	// Shift engine
	spiShiftEngine engine_i (
		.sysClk(sysClk), .rstN(rstN), .ctrl(ctrl), .start(start), .txByte(txByte),
		.miso(miso), .pins(pins), .busy(busy), .done(done), .rxByte(rxByte)
	);

	// Receive capture
	spiRxCapture rxCapture_i (
		.sysClk(sysClk), .rstN(rstN), .ctrl(ctrl), .start(start), .done(done),
		.rxByte(rxByte), .rxData(rxData), .doneFlag(doneFlag), .irq(irq)
	);

endmodule

`default_nettype wire

// ==== spiRxCapture.sv ====
/*
 * Receive capture of the SPI master block
 * Received byte holding register, done flag, gated interrupt pulse
 */
`timescale 1ns/10ps
`default_nettype none

module spiRxCapture
	import spiPkg::*;
(
	input  wire           sysClk,
	input  wire           rstN,
	input  wire spiCtrl_t ctrl,
	input  wire           start,
	input  wire           done,
	input  wire [7:0]     rxByte,
	output logic [7:0]    rxData,
	output logic          doneFlag,
	output logic          irq		// One cycle per finished transfer
);

	//--------------------------------------------------
	// Capture on done
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			rxData   <= 8'd0;
			doneFlag <= 1'b0;
			irq      <= 1'b0;
		end
		else
		begin
			irq <= done & ctrl.irqEn;		// Masked when irqEn clear
			if (done)
			begin
				rxData   <= rxByte;
				doneFlag <= 1'b1;
			end
			else if (start)
				doneFlag <= 1'b0;		// New transfer under way
		end
	end

endmodule

`default_nettype wire

// ==== spiShiftEngine.sv ====
/*
 * SPI shift engine, mode 0, MSB first, 8 bits per transfer
 * Half-period counter, transfer FSM, MOSI/MISO shift register, pin drive
 */
`timescale 1ns/10ps
`default_nettype none
`include "spiBlock_config.svh"

module spiShiftEngine
	import spiPkg::*;
(
	input  wire           sysClk,
	input  wire           rstN,
	input  wire spiCtrl_t ctrl,
	input  wire           start,
	input  wire [7:0]     txByte,
	input  wire           miso,
	output spiPins_t      pins,
	output logic          busy,
	output logic          done,		// One cycle, same edge busy falls
	output logic [7:0]    rxByte
);

	spiState_e               state;
	logic [`SPI_DIV_BIT-1:0] halfCnt;	// Clocks into the current half period
	logic                    halfEnd;
	logic [2:0]              bitCnt;
	logic [7:0]              shiftReg;	// TX out the top, RX in the bottom
	logic                    sckReg;
	logic                    mosiReg;

	assign halfEnd = (halfCnt == ctrl.div);	// div+1 clocks per half

	//--------------------------------------------------
	// Half-period counter
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			halfCnt <= '0;
		else if (state == IDLE || halfEnd)
			halfCnt <= '0;
		else
			halfCnt <= halfCnt + 1'b1;
	end

	//--------------------------------------------------
	// Transfer FSM
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			state    <= IDLE;
			bitCnt   <= 3'd0;
			busy     <= 1'b0;
			done     <= 1'b0;
			shiftReg <= 8'd0;
			sckReg   <= 1'b0;
			mosiReg  <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state    <= LEAD;
						bitCnt   <= 3'd0;
						busy     <= 1'b1;
						shiftReg <= txByte;
						mosiReg  <= txByte[7];		// Valid before the first rise
					end
				end
				LEAD:
				begin
					if (halfEnd)
						state <= SCK_LOW;
				end
				SCK_LOW:
				begin
					if (halfEnd)
					begin
						state    <= SCK_HIGH;
						sckReg   <= 1'b1;
						shiftReg <= {shiftReg[6:0], miso};	// Sample on the rise
					end
				end
				SCK_HIGH:
				begin
					if (halfEnd)
					begin
						sckReg <= 1'b0;
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= TRAIL;		// Eighth bit in
						else
						begin
							state   <= SCK_LOW;
							mosiReg <= shiftReg[7];	// Next bit on the fall
						end
					end
				end
				TRAIL:
				begin
					if (halfEnd)
					begin
						state   <= IDLE;
						busy    <= 1'b0;
						done    <= 1'b1;
						mosiReg <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign rxByte = shiftReg;

	// Pins, chip selects follow busy
	always_comb
	begin
		pins.sck  = sckReg;
		pins.mosi = mosiReg;
		pins.cs1N = ~(busy & ctrl.cs1Sel);
		pins.cs2N = ~(busy & ctrl.cs2Sel);
	end

endmodule

`default_nettype wire

// ==== spiCsr.sv ====
/*
 * Register file of the SPI master block, bus slave side
 * Block decode, CTRL and DIV registers, transfer start strobe, registered read mux
 */
`timescale 1ns/10ps
`default_nettype none
`include "spiBlock_config.svh"

module spiCsr
	import spiPkg::*;
(
	input  wire         sysClk,
	input  wire         rstN,
	input  wire busWr_t busWr,
	input  wire         rdCke,		// Read strobe, address on busWr.adrs
	input  wire         busy,
	input  wire [7:0]   rxData,
	input  wire         doneFlag,
	output busRd_t      busRd,
	output spiCtrl_t    ctrl,
	output logic        start,		// One cycle
	output logic [7:0]  txByte
);

	logic        blkHit;
	logic        wrHit;
	logic        rdHit;
	logic        txWr;
	csrReg_e     regOfs;
	logic [31:0] rdMux;

	//--------------------------------------------------
	// Address decode
	//--------------------------------------------------
	assign blkHit = (busWr.adrs[`SPI_BUS_ADRS_BIT-1 -: `SPI_BLOCK_ADRS_MAP] == `SPI_ADRS_MAP);
	assign wrHit  = busWr.wCke & blkHit;
	assign rdHit  = rdCke & blkHit;
	assign regOfs = csrReg_e'(busWr.adrs[`SPI_REG_OFS_BIT-1:0]);
	assign txWr   = wrHit && (regOfs == REG_TX);

	// CTRL and DIV
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			ctrl <= '0;
		else if (wrHit)
		begin
			case (regOfs)
				REG_CTRL:
				begin
					ctrl.enable <= busWr.wd[0];
					ctrl.cs1Sel <= busWr.wd[1];
					ctrl.cs2Sel <= busWr.wd[2];
					ctrl.irqEn  <= busWr.wd[3];
				end
				REG_DIV: ctrl.div <= busWr.wd[`SPI_DIV_BIT-1:0];
				default: ctrl <= ctrl;		// TX, RX, STATUS hold nothing here
			endcase
		end
	end

	// TX write becomes start, dropped when disabled or busy
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			start  <= 1'b0;
			txByte <= 8'd0;
		end
		else
		begin
			start <= txWr && ctrl.enable && !busy;
			if (txWr)
				txByte <= busWr.wd[7:0];
		end
	end

	//--------------------------------------------------
	// Read path
	//--------------------------------------------------
	always_comb
	begin
		case (regOfs)
			REG_CTRL:   rdMux = {28'd0, ctrl.irqEn, ctrl.cs2Sel, ctrl.cs1Sel, ctrl.enable};
			REG_DIV:    rdMux = {{(32-`SPI_DIV_BIT){1'b0}}, ctrl.div};
			REG_RX:     rdMux = {24'd0, rxData};
			REG_STATUS: rdMux = {30'd0, doneFlag, busy};
			default:    rdMux = 32'd0;		// TX reads as zero
		endcase
	end

	// vd one cycle after the strobe
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			busRd <= '0;
		else
		begin
			busRd.vd <= rdHit;
			busRd.rd <= rdHit ? rdMux : 32'd0;
		end
	end

endmodule

`default_nettype wire

// ==== spiPkg.sv ====
/*
 * Shared types of the SPI master block
 * Register offsets, FSM states, control word, bus and pin bundles
 */
`default_nettype none
`include "spiBlock_config.svh"

package spiPkg;

	typedef enum logic [`SPI_REG_OFS_BIT-1:0] {
		REG_CTRL   = 0,		// [0] enable [1] cs1Sel [2] cs2Sel [3] irqEn
		REG_DIV    = 1,		// Half SCK period minus one
		REG_TX     = 2,		// Write only, kicks a transfer
		REG_RX     = 3,		// Last received byte
		REG_STATUS = 4		// [0] busy [1] done
	} csrReg_e;

	// Shift engine FSM
	typedef enum logic [2:0] {IDLE, LEAD, SCK_LOW, SCK_HIGH, TRAIL} spiState_e;

	typedef struct packed {
		logic enable;
		logic cs1Sel;
		logic cs2Sel;
		logic irqEn;
		logic [`SPI_DIV_BIT-1:0] div;
	} spiCtrl_t;

	// Register bus, master to slave
	typedef struct packed {
		logic [`SPI_BUS_ADRS_BIT-1:0] adrs;
		logic [31:0] wd;
		logic wCke;
	} busWr_t;

	typedef struct packed {
		logic [31:0] rd;	// Zero when not addressed
		logic vd;
	} busRd_t;

	typedef struct packed {
		logic sck;
		logic mosi;
		logic cs1N;
		logic cs2N;
	} spiPins_t;

endpackage

`default_nettype wire

// ==== spiBlock_config.svh ====
/*
 * Configuration macros of the SPI master block
 * Bus address width, block address map, divider width, register offset field
 */
`ifndef SPIBLOCK_CONFIG_SVH
`define SPIBLOCK_CONFIG_SVH

//--------------------------------------------------
// Bus and address map
//--------------------------------------------------
`define SPI_BUS_ADRS_BIT	16		// Register bus address width
`define SPI_BLOCK_ADRS_MAP	8		// Upper address bits that pick the block
`define SPI_ADRS_MAP		8'h03	// Block select value

//--------------------------------------------------
// Block internals
//--------------------------------------------------
`define SPI_DIV_BIT		16		// SCK half-period divider width
`define SPI_REG_OFS_BIT	3		// Register offset field, low address bits

`endif
